/* src/interrupt_pkg.sv */
package interrupt_pkg;

  // --------------------------------------------------------------------------
  // savestate bus
  // --------------------------------------------------------------------------

  typedef logic [7:0]  ss_addr_t;
  typedef logic [31:0] ss_data_t;

  // one slot per block with state
  localparam ss_addr_t SS_INPUT   = 8'h10;
  localparam ss_addr_t SS_TIMER   = 8'h11;
  localparam ss_addr_t SS_ARBITER = 8'h12;

  // single-cycle addressed command, no back-pressure
  typedef struct packed {
    ss_data_t data;
    ss_addr_t addr;
    logic     wren;
    logic     bus_reset;
  } ss_bus_t;

  // --------------------------------------------------------------------------
  // interrupt factors
  // --------------------------------------------------------------------------

  // bit 0 is K0, bit 1 is K1
  typedef logic [1:0] input_factor_t;

  // bit 0 is the fastest timer tick
  typedef logic [3:0] timer_factor_t;

  typedef struct packed {
    input_factor_t inputs;
    timer_factor_t timer;
  } factor_set_t;

  typedef logic [2:0] irq_vector_t;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_PENDING,
    ARB_ACK_WAIT
  } arb_state_t;

endpackage

/* src/bus_connector.sv */
`timescale 1ns/1ps

module bus_connector
  import interrupt_pkg::*;
#(
  parameter ss_addr_t ADDRESS       = '0,
  parameter ss_data_t DEFAULT_VALUE = '0
) (
  input  logic     clk,

  input  ss_bus_t  ss_bus,
  output ss_data_t bus_out,

  input  ss_data_t current_data,
  output ss_data_t new_data
);

  ss_data_t stored;
  logic     selected;

  assign selected = (ss_bus.addr == ADDRESS);

  // the stored word is what the block reloads while its reset is held
  always_ff @(posedge clk) begin
    if (ss_bus.bus_reset) begin
      stored <= DEFAULT_VALUE;
    end else if (ss_bus.wren && selected) begin
      stored <= ss_bus.data;
    end
  end

  assign new_data = stored;

  // readback shows the live block state, not the stored word
  assign bus_out = selected ? current_data : '0;

endmodule

/* src/input_lines.sv */
`timescale 1ns/1ps

module input_lines
  import interrupt_pkg::*;
(
  input  logic          clk,
  input  logic          clk_en,
  input  logic          reset,

  input  logic [3:0]    input_k0,
  input  logic [3:0]    input_k1,

  input  logic [3:0]    input_relation_k0,
  input  logic [3:0]    input_k0_mask,
  input  logic [3:0]    input_k1_mask,

  input  logic          reset_factor,
  output input_factor_t factor_flags,

  input  ss_bus_t       ss_bus,
  output ss_data_t      ss_bus_out
);

  logic [3:0] prev_k0;
  logic [3:0] prev_k1;
  logic [3:0] k0_rise;
  logic [3:0] k0_fall;
  logic [3:0] k0_edge;
  logic [3:0] k1_edge;
  ss_data_t   ss_current;
  ss_data_t   ss_new;

  // --------------------------------------------------------------------------
  // edge detection
  // --------------------------------------------------------------------------

  assign k0_rise = input_k0 & ~prev_k0;
  assign k0_fall = ~input_k0 & prev_k0;

  // relation high picks the falling edge for that K0 line
  assign k0_edge = input_k0_mask &
                   ((input_relation_k0 & k0_fall) | (~input_relation_k0 & k0_rise));

  // K1 lines only ever trigger on a falling edge
  assign k1_edge = input_k1_mask & ~input_k1 & prev_k1;

  // --------------------------------------------------------------------------
  // sticky flags
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      factor_flags <= ss_new[1:0];
      // no edge is seen on the first cycle out of reset
      prev_k0      <= input_k0;
      prev_k1      <= input_k1;
    end else if (clk_en) begin
      prev_k0 <= input_k0;
      prev_k1 <= input_k1;
      if (reset_factor) begin
        factor_flags <= '0;
      end else begin
        factor_flags <= factor_flags | {|k1_edge, |k0_edge};
      end
    end
  end

  assign ss_current = {30'b0, factor_flags};

  bus_connector #(
    .ADDRESS       (SS_INPUT),
    .DEFAULT_VALUE ('0)
  ) u_bus_connector (
    .clk          (clk),
    .ss_bus       (ss_bus),
    .bus_out      (ss_bus_out),
    .current_data (ss_current),
    .new_data     (ss_new)
  );

  // a flag that goes up must have been set on a counted cycle
  assert property (@(posedge clk) disable iff (reset)
    !clk_en |=> (factor_flags & ~$past(factor_flags)) == '0)
    else $error("input factor flag rose on a cycle without clk_en");

endmodule

/* src/clock_timer.sv */
`timescale 1ns/1ps

module clock_timer
  import interrupt_pkg::*;
#(
  parameter int TICK_DIV = 256
) (
  input  logic          clk,
  input  logic          clk_en,
  input  logic          reset,

  input  logic          reset_factor,
  output timer_factor_t factor_flags,

  input  ss_bus_t       ss_bus,
  output ss_data_t      ss_bus_out
);

  localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [PRE_W-1:0] prescaler;
  logic [3:0]       divider;
  logic             base_tick;
  timer_factor_t    tick;
  ss_data_t         ss_current;
  ss_data_t         ss_new;

  // --------------------------------------------------------------------------
  // prescaler and ripple divider
  // --------------------------------------------------------------------------

  // one strobe every TICK_DIV clk_en pulses
  assign base_tick = clk_en && (int'(prescaler) == TICK_DIV - 1);

  // stage n fires when all lower divider stages are about to roll over,
  // which gives a period of TICK_DIV * 2**n pulses
  always_comb begin
    tick[0] = base_tick;
    tick[1] = base_tick & divider[0];
    tick[2] = base_tick & (&divider[1:0]);
    tick[3] = base_tick & (&divider[2:0]);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      factor_flags <= ss_new[3:0];
      divider      <= ss_new[7:4];
      prescaler    <= ss_new[8 +: PRE_W];
    end else if (clk_en) begin
      if (reset_factor) begin
        // clearing the factors also restarts the divider chain
        factor_flags <= '0;
        divider      <= '0;
        prescaler    <= '0;
      end else begin
        factor_flags <= factor_flags | tick;
        if (base_tick) begin
          prescaler <= '0;
          divider   <= divider + 1'b1;
        end else begin
          prescaler <= prescaler + 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // savestate slot
  // --------------------------------------------------------------------------

  // flags in [3:0], divider in [7:4], prescaler from bit 8 up
  always_comb begin
    ss_current               = '0;
    ss_current[3:0]          = factor_flags;
    ss_current[7:4]          = divider;
    ss_current[8 +: PRE_W]   = prescaler;
  end

  bus_connector #(
    .ADDRESS       (SS_TIMER),
    .DEFAULT_VALUE ('0)
  ) u_bus_connector (
    .clk          (clk),
    .ss_bus       (ss_bus),
    .bus_out      (ss_bus_out),
    .current_data (ss_current),
    .new_data     (ss_new)
  );

  // a restored or running prescaler stays inside one tick period
  assert property (@(posedge clk) disable iff (reset)
    int'(prescaler) < TICK_DIV)
    else $error("timer prescaler passed TICK_DIV");

endmodule

/* src/interrupt_arbiter.sv */
`timescale 1ns/1ps

module interrupt_arbiter
  import interrupt_pkg::*;
(
  input  logic        clk,
  input  logic        clk_en,
  input  logic        reset,

  input  factor_set_t factors,
  input  logic [5:0]  enable_mask,

  input  logic        irq_ack,
  output logic        irq,
  output irq_vector_t irq_vector,

  input  ss_bus_t     ss_bus,
  output ss_data_t    ss_bus_out
);

  arb_state_t  state;
  logic [5:0]  request;
  irq_vector_t next_vector;
  ss_data_t    ss_current;
  ss_data_t    ss_new;

  // bit position is the vector number, timer bit 3 ranks above bit 0
  assign request = enable_mask & {factors.timer[0], factors.timer[1],
                                  factors.timer[2], factors.timer[3],
                                  factors.inputs[1], factors.inputs[0]};

  // the lowest set request bit wins
  always_comb begin
    next_vector = '0;
    for (int i = 5; i >= 0; i--) begin
      if (request[i]) begin
        next_vector = irq_vector_t'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= arb_state_t'(ss_new[1:0]);
      irq_vector <= ss_new[4:2];
      irq        <= ss_new[5];
    end else if (clk_en) begin
      case (state)
        ARB_IDLE: begin
          if (|request) begin
            state      <= ARB_PENDING;
            irq        <= 1'b1;
            irq_vector <= next_vector;
          end
        end
        ARB_PENDING: begin
          if (irq_ack) begin
            state <= ARB_ACK_WAIT;
            irq   <= 1'b0;
          end
        end
        // one cycle for the handler to clear the factor it took
        ARB_ACK_WAIT: state <= ARB_IDLE;
        default: begin
          state <= ARB_IDLE;
          irq   <= 1'b0;
        end
      endcase
    end
  end

  assign ss_current = {26'b0, irq, irq_vector, state};

  bus_connector #(
    .ADDRESS       (SS_ARBITER),
    .DEFAULT_VALUE ('0)
  ) u_bus_connector (
    .clk          (clk),
    .ss_bus       (ss_bus),
    .bus_out      (ss_bus_out),
    .current_data (ss_current),
    .new_data     (ss_new)
  );

  // also catches an inconsistent restore from the savestate
  assert property (@(posedge clk) disable iff (reset)
    irq |-> state == ARB_PENDING)
    else $error("irq high outside ARB_PENDING");

  assert property (@(posedge clk) disable iff (reset)
    irq && $past(irq) |-> $stable(irq_vector))
    else $error("irq_vector changed while irq was held");

endmodule

/* src/interrupt_subsystem.sv */
`timescale 1ns/1ps

module interrupt_subsystem
  import interrupt_pkg::*;
#(
  parameter int TICK_DIV = 256
) (
  input  logic          clk,
  input  logic          clk_en,
  input  logic          reset,

  // input ports and their configuration
  input  logic [3:0]    input_k0,
  input  logic [3:0]    input_k1,
  input  logic [3:0]    input_relation_k0,
  input  logic [3:0]    input_k0_mask,
  input  logic [3:0]    input_k1_mask,

  input  logic          reset_input_factor,
  input  logic          reset_timer_factor,

  // interrupt request to the core
  input  logic [5:0]    enable_mask,
  input  logic          irq_ack,
  output logic          irq,
  output irq_vector_t   irq_vector,

  output input_factor_t input_factor,
  output timer_factor_t timer_factor,

  input  ss_bus_t       ss_bus,
  output ss_data_t      ss_bus_out
);

  factor_set_t factors;
  ss_data_t    ss_out_input;
  ss_data_t    ss_out_timer;
  ss_data_t    ss_out_arbiter;

  // --------------------------------------------------------------------------
  // factor sources
  // --------------------------------------------------------------------------

  input_lines u_input_lines (
    .clk               (clk),
    .clk_en            (clk_en),
    .reset             (reset),
    .input_k0          (input_k0),
    .input_k1          (input_k1),
    .input_relation_k0 (input_relation_k0),
    .input_k0_mask     (input_k0_mask),
    .input_k1_mask     (input_k1_mask),
    .reset_factor      (reset_input_factor),
    .factor_flags      (input_factor),
    .ss_bus            (ss_bus),
    .ss_bus_out        (ss_out_input)
  );

  clock_timer #(
    .TICK_DIV (TICK_DIV)
  ) u_clock_timer (
    .clk          (clk),
    .clk_en       (clk_en),
    .reset        (reset),
    .reset_factor (reset_timer_factor),
    .factor_flags (timer_factor),
    .ss_bus       (ss_bus),
    .ss_bus_out   (ss_out_timer)
  );

  // --------------------------------------------------------------------------
  // arbitration
  // --------------------------------------------------------------------------

  assign factors.inputs = input_factor;
  assign factors.timer  = timer_factor;

  interrupt_arbiter u_interrupt_arbiter (
    .clk         (clk),
    .clk_en      (clk_en),
    .reset       (reset),
    .factors     (factors),
    .enable_mask (enable_mask),
    .irq_ack     (irq_ack),
    .irq         (irq),
    .irq_vector  (irq_vector),
    .ss_bus      (ss_bus),
    .ss_bus_out  (ss_out_arbiter)
  );

  // only the addressed slot drives a nonzero readback
  assign ss_bus_out = ss_out_input | ss_out_timer | ss_out_arbiter;

endmodule

/* verification/interrupt_subsystem_tb.sv */
`timescale 1ns/1ps

module interrupt_subsystem_tb
  import interrupt_pkg::*;
();

  localparam int TICK_DIV       = 4;
  // the six tests need a few hundred cycles and the limit leaves a wide margin
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int IRQ_WAIT_LIMIT = 100;

  logic          clk;
  logic          clk_en;
  logic          reset;
  logic [3:0]    input_k0;
  logic [3:0]    input_k1;
  logic [3:0]    input_relation_k0;
  logic [3:0]    input_k0_mask;
  logic [3:0]    input_k1_mask;
  logic          reset_input_factor;
  logic          reset_timer_factor;
  logic [5:0]    enable_mask;
  logic          irq_ack;
  logic          irq;
  irq_vector_t   irq_vector;
  input_factor_t input_factor;
  timer_factor_t timer_factor;
  ss_bus_t       ss_bus;
  ss_data_t      ss_bus_out;

  int errors;
  int tests_run;
  int tests_failed;
  int cycle_count;

  interrupt_subsystem #(
    .TICK_DIV (TICK_DIV)
  ) u_interrupt_subsystem (
    .clk                (clk),
    .clk_en             (clk_en),
    .reset              (reset),
    .input_k0           (input_k0),
    .input_k1           (input_k1),
    .input_relation_k0  (input_relation_k0),
    .input_k0_mask      (input_k0_mask),
    .input_k1_mask      (input_k1_mask),
    .reset_input_factor (reset_input_factor),
    .reset_timer_factor (reset_timer_factor),
    .enable_mask        (enable_mask),
    .irq_ack            (irq_ack),
    .irq                (irq),
    .irq_vector         (irq_vector),
    .input_factor       (input_factor),
    .timer_factor       (timer_factor),
    .ss_bus             (ss_bus),
    .ss_bus_out         (ss_bus_out)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run stopped by timeout after %0d cycles", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------

  logic [1:0]  m_input;
  logic [3:0]  m_timer;
  logic [3:0]  m_prev_k0;
  logic [3:0]  m_prev_k1;
  ss_data_t    m_input_slot;
  int          m_pulses;
  arb_state_t  m_state;
  logic        m_irq;
  irq_vector_t m_vector;
  ss_data_t    m_readback;

  always @(posedge clk) begin : model
    logic [1:0]  edges;
    logic [3:0]  ticks;
    logic [5:0]  masked;
    irq_vector_t pick;
    int          next_count;

    // a K0 line fires when it changes to the level opposite its relation bit
    edges[0] = |(input_k0_mask & (input_k0 ^ m_prev_k0) & (input_k0 ^ input_relation_k0));
    edges[1] = |(input_k1_mask & m_prev_k1 & ~input_k1);
    next_count = m_pulses + 1;
    ticks[0] = (next_count % TICK_DIV) == 0;
    ticks[1] = (next_count % (2 * TICK_DIV)) == 0;
    ticks[2] = (next_count % (4 * TICK_DIV)) == 0;
    ticks[3] = (next_count % (8 * TICK_DIV)) == 0;
    // vector order is K0, K1, then timer 3 down to timer 0
    masked = enable_mask & {m_timer[0], m_timer[1], m_timer[2], m_timer[3], m_input};
    casez (masked)
      6'b?????1: pick = 3'd0;
      6'b????10: pick = 3'd1;
      6'b???100: pick = 3'd2;
      6'b??1000: pick = 3'd3;
      6'b?10000: pick = 3'd4;
      6'b100000: pick = 3'd5;
      default:   pick = 3'd0;
    endcase
    if (ss_bus.bus_reset) begin
      m_input_slot <= '0;
    end else if (ss_bus.wren && ss_bus.addr == SS_INPUT) begin
      m_input_slot <= ss_bus.data;
    end
    if (reset) begin
      m_input   <= m_input_slot[1:0];
      m_prev_k0 <= input_k0;
      m_prev_k1 <= input_k1;
      m_timer   <= '0;
      m_pulses  <= 0;
      m_state   <= ARB_IDLE;
      m_irq     <= 1'b0;
      m_vector  <= '0;
    end else if (clk_en) begin
      m_prev_k0 <= input_k0;
      m_prev_k1 <= input_k1;
      m_input   <= reset_input_factor ? 2'b00 : (m_input | edges);
      if (reset_timer_factor) begin
        m_timer  <= '0;
        m_pulses <= 0;
      end else begin
        m_timer  <= m_timer | ticks;
        m_pulses <= next_count;
      end
      case (m_state)
        ARB_IDLE: begin
          if (|masked) begin
            m_state  <= ARB_PENDING;
            m_irq    <= 1'b1;
            m_vector <= pick;
          end
        end
        ARB_PENDING: begin
          if (irq_ack) begin
            m_state <= ARB_ACK_WAIT;
            m_irq   <= 1'b0;
          end
        end
        default: m_state <= ARB_IDLE;
      endcase
    end
  end

  assign m_readback = (ss_bus.addr == SS_INPUT) ? {30'b0, m_input} : '0;

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  assert property (@(posedge clk) disable iff (reset) input_factor == m_input)
    else begin
      errors++;
      $display("CHECK FAILED input_factor: got 0x%h, expected 0x%h",
               $sampled(input_factor), $sampled(m_input));
    end

  assert property (@(posedge clk) disable iff (reset) timer_factor == m_timer)
    else begin
      errors++;
      $display("CHECK FAILED timer_factor: got 0x%h, expected 0x%h",
               $sampled(timer_factor), $sampled(m_timer));
    end

  assert property (@(posedge clk) disable iff (reset) irq == m_irq)
    else begin
      errors++;
      $display("CHECK FAILED irq: got 0x%h, expected 0x%h", $sampled(irq), $sampled(m_irq));
    end

  assert property (@(posedge clk) disable iff (reset) irq |-> irq_vector == m_vector)
    else begin
      errors++;
      $display("CHECK FAILED irq_vector: got 0x%h, expected 0x%h",
               $sampled(irq_vector), $sampled(m_vector));
    end

  // timer and arbiter slots show internal state that is not modelled here
  assert property (@(posedge clk) disable iff (reset)
    (ss_bus.addr != SS_TIMER && ss_bus.addr != SS_ARBITER) |-> ss_bus_out == m_readback)
    else begin
      errors++;
      $display("CHECK FAILED ss_bus_out: got 0x%h, expected 0x%h",
               $sampled(ss_bus_out), $sampled(m_readback));
    end

  // --------------------------------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------------------------------

  task automatic clear_inputs();
    reset_input_factor = 1'b1;
    @(negedge clk);
    reset_input_factor = 1'b0;
  endtask

  task automatic clear_timer();
    reset_timer_factor = 1'b1;
    @(negedge clk);
    reset_timer_factor = 1'b0;
  endtask

  task automatic pulse_k0(input logic [1:0] line);
    input_k0[line] = 1'b1;
    @(negedge clk);
    input_k0[line] = 1'b0;
    @(negedge clk);
  endtask

  task automatic fall_k1(input logic [1:0] line);
    input_k1[line] = 1'b1;
    @(negedge clk);
    input_k1[line] = 1'b0;
    @(negedge clk);
  endtask

  task automatic wait_for_irq();
    int waited;
    waited = 0;
    while (!irq && waited < IRQ_WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!irq) begin
      errors++;
      $display("irq did not rise within %0d cycles", IRQ_WAIT_LIMIT);
    end
  endtask

  // the factor is cleared in the ARB_ACK_WAIT cycle
  task automatic acknowledge();
    irq_ack = 1'b1;
    @(negedge clk);
    irq_ack = 1'b0;
    clear_inputs();
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - errors_before);
    end
  endtask

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------

  initial begin
    int         errors_before;
    logic [1:0] k0_line;
    logic [1:0] k1_line;
    logic [1:0] other;
    ss_data_t   saved;

    void'($urandom(22202));
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    cycle_count = 0;
    clk_en = 1'b0;
    reset = 1'b1;
    input_k0 = '0;
    input_k1 = '0;
    input_relation_k0 = '0;
    input_k0_mask = '0;
    input_k1_mask = '0;
    reset_input_factor = 1'b0;
    reset_timer_factor = 1'b0;
    enable_mask = '0;
    irq_ack = 1'b0;
    ss_bus = '0;
    ss_bus.bus_reset = 1'b1;
    @(negedge clk);
    ss_bus.bus_reset = 1'b0;
    clk_en = 1'b1;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    errors_before = errors;
    k0_line = 2'($urandom % 4);
    other = k0_line + 2'($urandom % 3) + 2'd1;
    input_k0_mask[k0_line] = 1'b1;
    // the falling edge has to meet a clear flag to show that it is ignored
    input_k0[k0_line] = 1'b1;
    @(negedge clk);
    clear_inputs();
    input_k0[k0_line] = 1'b0;
    @(negedge clk);
    input_relation_k0[k0_line] = 1'b1;
    pulse_k0(k0_line);
    clear_inputs();
    pulse_k0(other);
    input_relation_k0[other] = 1'b1;
    pulse_k0(other);
    finish_test("K0 edges", errors_before);

    errors_before = errors;
    k1_line = 2'($urandom % 4);
    input_k1_mask[k1_line] = 1'b1;
    fall_k1(k1_line);
    clear_inputs();
    pulse_k0(k0_line);
    // a K1 falling edge in the same cycle as the clear
    input_k1[k1_line] = 1'b1;
    @(negedge clk);
    input_k1[k1_line] = 1'b0;
    clear_inputs();
    repeat (2) @(negedge clk);
    finish_test("K1 edges and clear", errors_before);

    errors_before = errors;
    clear_timer();
    repeat (8 * TICK_DIV + 2) @(negedge clk);
    clear_timer();
    repeat (TICK_DIV - 1) @(negedge clk);
    clk_en = 1'b0;
    repeat (10) @(negedge clk);
    clk_en = 1'b1;
    repeat (2 * TICK_DIV) @(negedge clk);
    for (int i = 0; i < 40; i++) begin
      clk_en = 1'($urandom % 2);
      @(negedge clk);
    end
    clk_en = 1'b1;
    finish_test("timer periods", errors_before);

    errors_before = errors;
    clear_inputs();
    clear_timer();
    enable_mask = 6'b000001;
    fall_k1(k1_line);
    repeat (3) @(negedge clk);
    pulse_k0(k0_line);
    wait_for_irq();
    acknowledge();
    enable_mask = 6'b111100;
    wait_for_irq();
    acknowledge();
    enable_mask = '0;
    clear_timer();
    finish_test("irq raise and priority", errors_before);

    errors_before = errors;
    fall_k1(k1_line);
    repeat (2 * TICK_DIV) @(negedge clk);
    enable_mask = 6'b111110;
    wait_for_irq();
    acknowledge();
    wait_for_irq();
    acknowledge();
    enable_mask = '0;
    clear_timer();
    finish_test("K1 over timer", errors_before);

    errors_before = errors;
    saved = $urandom;
    saved[1:0] = 2'($urandom % 3 + 1);
    ss_bus.data = saved;
    ss_bus.addr = SS_INPUT;
    ss_bus.wren = 1'b1;
    @(negedge clk);
    ss_bus.wren = 1'b0;
    ss_bus.addr = 8'h00;
    reset = 1'b1;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    ss_bus.addr = SS_INPUT;
    repeat (3) @(negedge clk);
    ss_bus.addr = 8'h3f;
    repeat (3) @(negedge clk);
    ss_bus.addr = 8'h00;
    @(negedge clk);
    finish_test("savestate restore and readback", errors_before);

    $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* files.f */
src/interrupt_pkg.sv
src/bus_connector.sv
src/input_lines.sv
src/clock_timer.sv
src/interrupt_arbiter.sv
src/interrupt_subsystem.sv
verification/interrupt_subsystem_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the interrupt subsystem testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -f files.f \
  --top-module interrupt_subsystem_tb

# the simulator output decides pass or fail
output=$(./obj_dir/Vinterrupt_subsystem_tb 2>&1) || true
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -q "Test completed successfully"
